// File: all.f
hw/det_pkg.sv
hw/matrix_ram.sv
hw/row_pointer_table.sv
hw/elim_pipe.sv
hw/diag_product.sv
hw/det_control.sv
hw/det_wb_regs.sv
hw/det_top.sv
dv/det_checker.sv
dv/det_tb.sv

// File: Makefile
SIM = obj_dir/Vdet_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module det_tb -f all.f

run: compile
	./$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -q -- '>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/det_tb.sv
module det_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import det_pkg::*;

	localparam int DIM = 8;
	localparam int CLK_PERIOD = 40;
	localparam int CASE_CYCLES = 2 * DIM * DIM + DIM * DIM * DIM + 64; // load plus worst compute
	localparam int WATCHDOG_NS = 64 * CASE_CYCLES * CLK_PERIOD;

	typedef struct packed {
		fix_t value;
		logic singular;
	} det_expect_t;

	logic clk;
	logic reset;
	logic wb_cyc, wb_stb, wb_we;
	wb_addr_t wb_adr;
	fix_t wb_dat_w;
	fix_t wb_dat_r;
	logic wb_ack;

	logic [31:0] lfsr;
	fix_t mat [DIM*DIM]; // host copy of the matrix, row major
	int n_cases;

	det_top #(.MAX_N(DIM)) det_top_i (
		.clk(clk), .reset(reset),
		.i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we),
		.i_wb_adr(wb_adr), .i_wb_dat(wb_dat_w),
		.o_wb_dat(wb_dat_r), .o_wb_ack(wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic fail_stop();
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish in the allowed time");
		fail_stop();
	end

	// bound assertions count their failures
	initial begin
		do begin
			@(negedge clk);
		end while (det_top_i.det_checker_i.fail_cnt == 0);
		$display("a bound checker assertion failed");
		fail_stop();
	end

	//////////////////////////////
	// random source
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps 32 22 2 1
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int width);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < width; i++) v = {v[30:0], lfsr_step()}; // one step per bit
		return v;
	endfunction

	function automatic fix_t rand_elem();
		logic [31:0] v;
		v = rand_bits(18);
		return fix_t'({{14{v[17]}}, v[17:0]}); // -2.0 .. 2.0
	endfunction

	//////////////////////////////
	// matrix builders
	function automatic void clear_matrix();
		for (int i = 0; i < DIM * DIM; i++) mat[i] = '0;
	endfunction

	function automatic void fill_random(input int n);
		for (int r = 0; r < n; r++) begin
			for (int c = 0; c < n; c++) mat[r * DIM + c] = rand_elem();
		end
	endfunction

	function automatic void fill_diagonal(input int n);
		for (int r = 0; r < n; r++) mat[r * DIM + r] = rand_elem();
	endfunction

	function automatic void fill_anti_diagonal(input int n);
		for (int r = 0; r < n; r++) begin
			mat[r * DIM + (n - 1 - r)] = fix_t'(FIX_ONE + fix_t'(rand_bits(16))); // 1.0 .. 2.0
		end
	endfunction

	//////////////////////////////
	// reference model
	function automatic det_expect_t ref_det(input int n);
		fix_t mem [DIM*DIM];
		int rb [DIM]; // logical row to physical base
		int tmp;
		int cnt;
		logic neg;
		fix_t piv;
		fix_t coef;
		fix_t acc;
		longint wide;
		det_expect_t res;
		for (int i = 0; i < DIM * DIM; i++) mem[i] = mat[i];
		for (int v = 0; v < DIM; v++) rb[v] = v * DIM;
		neg = 1'b0;
		res.value = '1;
		res.singular = 1'b0;
		for (int k = 0; k < n - 1; k++) begin
			cnt = 0;
			while (mem[rb[k] + k] == '0) begin
				if (cnt == n - k - 1) begin
					res.singular = 1'b1; // whole column tried
					return res;
				end
				tmp = rb[n - 1]; // last active row to the top
				for (int v = n - 1; v > k; v--) rb[v] = rb[v - 1];
				rb[k] = tmp;
				if ((n - k) % 2 == 0) neg = ~neg;
				cnt++;
			end
			piv = mem[rb[k] + k];
			for (int i = k + 1; i < n; i++) begin
				wide = (longint'(mem[rb[i] + k]) <<< 16) / longint'(piv); // toward zero
				coef = fix_t'(wide);
				for (int j = k + 1; j < n; j++) begin
					wide = (longint'(coef) * longint'(mem[rb[k] + j])) >>> 16;
					mem[rb[i] + j] = mem[rb[i] + j] - fix_t'(wide);
				end
			end
		end
		acc = FIX_ONE;
		for (int i = 0; i < n; i++) begin
			wide = (longint'(acc) * longint'(mem[rb[i] + i])) >>> 16; // diagonal in row order
			acc = fix_t'(wide);
		end
		res.value = neg ? -acc : acc;
		return res;
	endfunction

	//////////////////////////////
	// compare tasks
	task automatic check_fix(input string name, input fix_t got, input fix_t exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
			fail_stop();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
			fail_stop();
		end
	endtask

	//////////////////////////////
	// wishbone host
	task automatic wb_access(input logic we, input wb_addr_t adr, input fix_t wdat,
		output fix_t rdat);
		int waited;
		waited = 0;
		@(posedge clk);
		#2;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdat;
		do begin
			@(posedge clk);
			#1; // outputs settled
			waited++;
			if (waited > 4) begin
				$display("no wishbone ack within four cycles of a request");
				fail_stop();
			end
		end while (!wb_ack);
		rdat = wb_dat_r; // data comes with the ack
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_write(input wb_addr_t adr, input fix_t dat);
		fix_t ignored;
		wb_access(1'b1, adr, dat, ignored);
	endtask

	task automatic wb_read(input wb_addr_t adr, output fix_t dat);
		wb_access(1'b0, adr, '0, dat);
	endtask

	// load, start, wait for done, compare
	task automatic run_case(input int n, input logic poke_busy);
		det_expect_t exp;
		fix_t rd;
		int polls;
		exp = ref_det(n);
		for (int r = 0; r < n; r++) begin
			for (int c = 0; c < n; c++) wb_write(wb_addr_t'(r * DIM + c), mat[r * DIM + c]);
		end
		for (int i = 0; i < n; i++) begin
			wb_read(wb_addr_t'(i * DIM + i), rd); // host read through port A
			check_fix("matrix word", rd, mat[i * DIM + i]);
		end
		wb_write(WB_CTRL, fix_t'(32'h0000_0100 | n)); // start bit plus size
		if (poke_busy) wb_write(wb_addr_t'(0), 32'sh7fff_0000); // must be dropped
		polls = 0;
		do begin
			wb_read(WB_STATUS, rd);
			polls++;
			if (polls > CASE_CYCLES) begin
				$display("done bit never set for a size %0d matrix", n);
				fail_stop();
			end
		end while (!rd[1]);
		check_flag("busy", rd[0], 1'b0);
		check_flag("singular", rd[2], exp.singular);
		wb_read(WB_RESULT, rd);
		check_fix("result", rd, exp.value);
		n_cases++;
	endtask

	//////////////////////////////
	// test sequence
	initial begin
		fix_t rd;
		lfsr = 32'h9f87_8d46;
		n_cases = 0;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;

		wb_read(WB_STATUS, rd); // idle after reset
		check_fix("status", rd, '0);
		wb_read(WB_RESULT, rd);
		check_fix("result", rd, '0);

		clear_matrix(); // single element
		fill_random(1);
		run_case(1, 1'b0);
		for (int n = 2; n <= DIM; n++) begin
			clear_matrix();
			fill_diagonal(n);
			run_case(n, 1'b0);
		end

		for (int pass = 0; pass < 2; pass++) begin
			for (int n = 2; n <= DIM; n++) begin
				clear_matrix();
				fill_random(n);
				run_case(n, 1'b0);
			end
		end

		// zero leading pivots, one and two rotations
		for (int n = 3; n <= 6; n++) begin
			clear_matrix();
			fill_random(n);
			mat[0] = '0;
			run_case(n, 1'b0);
		end
		for (int n = 4; n <= 7; n++) begin
			clear_matrix();
			fill_random(n);
			mat[0] = '0;
			mat[(n - 1) * DIM] = '0; // rotated-in row is zero too
			run_case(n, 1'b0);
		end
		for (int n = 3; n <= 6; n++) begin
			clear_matrix();
			fill_anti_diagonal(n); // rotation at every step
			run_case(n, 1'b0);
		end

		// zero first column, host writes while busy
		clear_matrix();
		fill_random(6);
		for (int r = 0; r < 6; r++) mat[r * DIM] = '0;
		run_case(6, 1'b1);
		clear_matrix();
		fill_random(DIM);
		for (int r = 0; r < DIM; r++) mat[r * DIM] = '0;
		run_case(DIM, 1'b1);
		clear_matrix();
		fill_random(DIM);
		run_case(DIM, 1'b1);

		if (det_top_i.det_checker_i.fail_cnt != 0) begin
			$display("checker assertions failed %0d times", det_top_i.det_checker_i.fail_cnt);
			fail_stop();
		end else begin
			$display("%0d determinant cases matched", n_cases);
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

// File: dv/det_checker.sv
module det_checker (
	input logic clk,
	input logic reset,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_ack,
	input logic i_busy,
	input det_pkg::ram_req_t i_req_b
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned fail_cnt; // watched by the testbench

	initial fail_cnt = 0;

	//////////////////////////////
	// wishbone handshake
	ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
		i_wb_ack |=> !i_wb_ack)
		else begin
			fail_cnt++;
			$error("wishbone ack high for more than one cycle");
		end

	ack_after_req: assert property (@(posedge clk) disable iff (reset)
		i_wb_ack |-> $past(i_wb_cyc && i_wb_stb)) // registered ack
		else begin
			fail_cnt++;
			$error("wishbone ack without a preceding cyc and stb");
		end

	//////////////////////////////
	// elimination write port
	we_b_only_busy: assert property (@(posedge clk) disable iff (reset)
		i_req_b.we |-> i_busy)
		else begin
			fail_cnt++;
			$error("port B write enable high while the engine is idle");
		end

endmodule

bind det_top det_checker det_checker_i (
	.clk(clk), .reset(reset),
	.i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_ack(o_wb_ack),
	.i_busy(busy), .i_req_b(elim_req_b)
);

// File: hw/det_top.sv
module det_top #(
	parameter int MAX_N = det_pkg::MAX_N
) (
	input logic clk,
	input logic reset,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_we,
	input det_pkg::wb_addr_t i_wb_adr,
	input det_pkg::fix_t i_wb_dat,
	output det_pkg::fix_t o_wb_dat,
	output logic o_wb_ack
);
	import det_pkg::*;

	logic busy, done, singular, start;
	logic rotate, init_rows, neg;
	logic elim_go, elim_done, diag_go, diag_done;
	size_t size;
	idx_t k;
	fix_t result, diag_result, q_a, q_b;
	ram_req_t host_req, port_a, elim_req_a, elim_req_b, diag_req;
	row_base_t row_base;

	//////////////////////////////
	// host side
	det_wb_regs det_wb_regs_i (
		.clk(clk), .reset(reset),
		.i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
		.i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat),
		.i_busy(busy), .i_done(done), .i_singular(singular),
		.i_result(result), .i_ram_q(q_a),
		.o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
		.o_host_req(host_req), .o_start(start), .o_size(size)
	);

	det_control det_control_i (
		.clk(clk), .reset(reset), .i_start(start), .i_size(size),
		.i_host_req(host_req), .i_elim_req_a(elim_req_a), .i_diag_req(diag_req),
		.i_q_a(q_a), .i_row_base(row_base),
		.i_elim_done(elim_done), .i_diag_done(diag_done), .i_diag_result(diag_result),
		.o_busy(busy), .o_done(done), .o_singular(singular), .o_result(result),
		.o_port_a(port_a), .o_rotate(rotate), .o_init_rows(init_rows),
		.o_elim_go(elim_go), .o_diag_go(diag_go), .o_k(k)
	);

	//////////////////////////////
	// datapath
	row_pointer_table row_pointer_table_i (
		.clk(clk), .reset(reset), .i_init(init_rows), .i_rotate(rotate),
		.i_k(k), .i_size(size), .o_row_base(row_base), .o_neg(neg)
	);

	matrix_ram #(.MAX_N(MAX_N)) matrix_ram_i (
		.clk(clk), .i_port_a(port_a), .i_port_b(elim_req_b),
		.o_q_a(q_a), .o_q_b(q_b)
	);

	elim_pipe elim_pipe_i (
		.clk(clk), .reset(reset), .i_go(elim_go), .i_k(k), .i_size(size),
		.i_row_base(row_base), .i_q_a(q_a), .i_q_b(q_b), .i_pivot(q_a),
		.o_req_a(elim_req_a), .o_req_b(elim_req_b), .o_done(elim_done)
	);

	diag_product diag_product_i (
		.clk(clk), .reset(reset), .i_go(diag_go), .i_size(size),
		.i_row_base(row_base), .i_q(q_a), .i_neg(neg),
		.o_req(diag_req), .o_result(diag_result), .o_done(diag_done)
	);

endmodule

// File: hw/det_wb_regs.sv
module det_wb_regs (
	input logic clk,
	input logic reset,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_we,
	input det_pkg::wb_addr_t i_wb_adr,
	input det_pkg::fix_t i_wb_dat,
	input logic i_busy,
	input logic i_done,
	input logic i_singular,
	input det_pkg::fix_t i_result,
	input det_pkg::fix_t i_ram_q,
	output det_pkg::fix_t o_wb_dat,
	output logic o_wb_ack,
	output det_pkg::ram_req_t o_host_req,
	output logic o_start,
	output det_pkg::size_t o_size
);
	import det_pkg::*;

	logic req; // first cycle of an access
	logic is_mx; // matrix word window
	logic rd_mx; // acked access was a matrix word
	logic done_r;
	logic sing_r;
	fix_t result_r;
	fix_t reg_dat;

	assign req = i_wb_cyc & i_wb_stb & ~o_wb_ack; // ack low in between
	assign is_mx = i_wb_adr < wb_addr_t'(MAX_N * MAX_N);

	// port A request, control passes it on only while idle
	always_comb begin
		o_host_req.addr = mx_addr_t'(i_wb_adr);
		o_host_req.wdata = i_wb_dat;
		o_host_req.we = req & i_wb_we & is_mx & ~i_busy; // dropped while busy
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			o_wb_ack <= 1'b0;
			o_start <= 1'b0;
			o_size <= '0;
			done_r <= 1'b0;
			sing_r <= 1'b0;
			result_r <= '0;
		end else begin
			o_wb_ack <= req;
			o_start <= 1'b0;
			if (req && i_wb_we && i_wb_adr == WB_CTRL && !i_busy) begin
				o_size <= size_t'(i_wb_dat[4:0]); // n
				o_start <= i_wb_dat[8];
			end
			if (o_start) begin
				done_r <= 1'b0; // new run
				sing_r <= 1'b0;
			end else if (i_done) begin
				done_r <= 1'b1;
				sing_r <= i_singular;
				result_r <= i_result;
			end
		end
	end

	// read data, ram word lands during the ack cycle
	always_ff @(posedge clk) begin
		if (req) begin
			rd_mx <= is_mx;
			case (i_wb_adr)
				WB_CTRL: reg_dat <= fix_t'(o_size);
				WB_STATUS: reg_dat <= fix_t'({sing_r, done_r, i_busy});
				WB_RESULT: reg_dat <= result_r;
				default: reg_dat <= '0;
			endcase
		end
	end

	assign o_wb_dat = rd_mx ? i_ram_q : reg_dat;

endmodule

// File: hw/det_control.sv
module det_control (
	input logic clk,
	input logic reset,
	input logic i_start,
	input det_pkg::size_t i_size,
	input det_pkg::ram_req_t i_host_req,
	input det_pkg::ram_req_t i_elim_req_a,
	input det_pkg::ram_req_t i_diag_req,
	input det_pkg::fix_t i_q_a,
	input det_pkg::row_base_t i_row_base,
	input logic i_elim_done,
	input logic i_diag_done,
	input det_pkg::fix_t i_diag_result,
	output logic o_busy,
	output logic o_done,
	output logic o_singular,
	output det_pkg::fix_t o_result,
	output det_pkg::ram_req_t o_port_a,
	output logic o_rotate,
	output logic o_init_rows,
	output logic o_elim_go,
	output logic o_diag_go,
	output det_pkg::idx_t o_k
);
	import det_pkg::*;

	det_state_e state;
	size_t rot_cnt; // rotations tried at this k
	size_t m; // rows in active block
	logic pivot_zero;
	logic last_k; // k == n-2

	assign m = i_size - size_t'(o_k);
	assign pivot_zero = (i_q_a == '0);
	assign last_k = (o_k == idx_t'(i_size - size_t'(2)));

	assign o_busy = (state != ST_IDLE);
	assign o_done = (state == ST_FINISH);
	assign o_init_rows = (state == ST_SETUP);
	assign o_rotate = (state == ST_PIVOT_CHECK) && pivot_zero; // next row to the top
	assign o_elim_go = (state == ST_PIVOT_CHECK) && !pivot_zero; // pivot still on q_a
	assign o_diag_go = ((state == ST_SETUP) && (i_size == size_t'(1))) ||
		((state == ST_NEXT_ITER) && last_k);

	//////////////////////////////
	// port A owner
	always_comb begin
		o_port_a = '0;
		case (state)
			ST_IDLE: o_port_a = i_host_req;
			ST_PIVOT_READ, ST_PIVOT_CHECK: begin
				o_port_a.addr = i_row_base[o_k] + mx_addr_t'(o_k); // a(k,k)
			end
			ST_ELIM: o_port_a = i_elim_req_a;
			ST_DIAG: o_port_a = i_diag_req;
			default: o_port_a = '0;
		endcase
	end

	//////////////////////////////
	// main FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			o_k <= '0;
			rot_cnt <= '0;
			o_singular <= 1'b0;
			o_result <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_start) state <= ST_SETUP;
				end
				ST_SETUP: begin
					o_k <= '0;
					rot_cnt <= '0;
					o_singular <= 1'b0;
					state <= (i_size == size_t'(1)) ? ST_DIAG : ST_PIVOT_READ;
				end
				ST_PIVOT_READ: state <= ST_PIVOT_CHECK; // ram latency
				ST_PIVOT_CHECK: begin
					if (!pivot_zero) begin
						state <= ST_ELIM;
					end else if (rot_cnt == size_t'(m - size_t'(1))) begin
						o_singular <= 1'b1; // every row tried
						o_result <= '1;
						state <= ST_FINISH;
					end else begin
						rot_cnt <= rot_cnt + size_t'(1);
						state <= ST_PIVOT_READ; // probe the rotated row
					end
				end
				ST_ELIM: begin
					if (i_elim_done) state <= ST_NEXT_ITER;
				end
				ST_NEXT_ITER: begin
					o_k <= o_k + idx_t'(1);
					rot_cnt <= '0;
					state <= last_k ? ST_DIAG : ST_PIVOT_READ;
				end
				ST_DIAG: begin
					if (i_diag_done) begin
						o_result <= i_diag_result;
						state <= ST_FINISH;
					end
				end
				ST_FINISH: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: hw/diag_product.sv
module diag_product (
	input logic clk,
	input logic reset,
	input logic i_go,
	input det_pkg::size_t i_size,
	input det_pkg::row_base_t i_row_base,
	input det_pkg::fix_t i_q,
	input logic i_neg,
	output det_pkg::ram_req_t o_req,
	output det_pkg::fix_t o_result,
	output logic o_done
);
	import det_pkg::*;

	logic busy;
	logic phase; // 0 address out, 1 data back
	logic fin;
	idx_t idx; // diagonal index
	fix_t acc;
	logic signed [63:0] prod;

	assign prod = acc * i_q;

	always_comb begin
		o_req.addr = i_row_base[idx] + mx_addr_t'(idx); // a(idx,idx)
		o_req.wdata = '0;
		o_req.we = 1'b0; // read only
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			phase <= 1'b0;
			fin <= 1'b0;
			idx <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= fin;
			fin <= 1'b0;
			if (i_go) begin
				busy <= 1'b1;
				phase <= 1'b0;
				idx <= '0;
			end else if (busy) begin
				phase <= ~phase;
				if (phase) begin
					idx <= idx + idx_t'(1);
					if (idx == idx_t'(i_size - size_t'(1))) begin
						busy <= 1'b0; // last element folded
						fin <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_go) acc <= FIX_ONE;
		else if (busy && phase) acc <= fix_t'(prod >>> 16);
		if (fin) o_result <= i_neg ? -acc : acc; // rotation parity
	end

endmodule

// File: hw/elim_pipe.sv
module elim_pipe (
	input logic clk,
	input logic reset,
	input logic i_go,
	input det_pkg::idx_t i_k,
	input det_pkg::size_t i_size,
	input det_pkg::row_base_t i_row_base,
	input det_pkg::fix_t i_q_a,
	input det_pkg::fix_t i_q_b,
	input det_pkg::fix_t i_pivot,
	output det_pkg::ram_req_t o_req_a,
	output det_pkg::ram_req_t o_req_b,
	output logic o_done
);
	import det_pkg::*;

	fix_t row_buf [MAX_N-1]; // pivot row right of the diagonal
	fix_t col_buf [MAX_N-1]; // pivot column below the diagonal
	fix_t pivot;

	logic pre, sweep;
	idx_t pc; // preload count
	idx_t r, c; // submatrix offsets
	idx_t last; // m-2
	idx_t k1; // first index past the pivot
	logic signed [47:0] num, quot;
	logic signed [63:0] prod;

	logic s1_valid, s2_valid, s3_valid;
	logic s1_last, s2_last;
	mx_addr_t s1_addr, s2_addr, s3_addr;
	fix_t s1_coef, s1_top, s2_elem, s2_prod, s3_data;

	assign last = idx_t'(i_size - size_t'(i_k) - size_t'(2));
	assign k1 = i_k + idx_t'(1);
	assign num = {col_buf[r], 16'h0000};
	assign quot = num / pivot; // truncates toward zero
	assign prod = s1_coef * s1_top;

	//////////////////////////////
	// ram requests
	always_comb begin
		o_req_a = '0;
		o_req_b = '0;
		if (sweep) begin
			o_req_a.addr = i_row_base[idx_t'(k1 + r)] + mx_addr_t'(idx_t'(k1 + c));
		end else begin
			o_req_a.addr = i_row_base[i_k] + mx_addr_t'(idx_t'(k1 + pc)); // a(k, k+1+pc)
		end
		if (s3_valid) begin
			o_req_b.addr = s3_addr; // write back in place
			o_req_b.wdata = s3_data;
			o_req_b.we = 1'b1;
		end else begin
			o_req_b.addr = i_row_base[idx_t'(k1 + pc)] + mx_addr_t'(i_k); // a(k+1+pc, k)
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pre <= 1'b0;
			sweep <= 1'b0;
			pc <= '0;
			r <= '0;
			c <= '0;
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
			o_done <= 1'b0;
		end else begin
			s1_valid <= sweep;
			s2_valid <= s1_valid;
			s3_valid <= s2_valid;
			o_done <= s2_valid && s2_last; // with the final write
			if (i_go) begin
				pre <= 1'b1;
				pc <= '0;
			end else if (pre) begin
				pc <= pc + idx_t'(1);
				if (pc == last + idx_t'(1)) begin
					pre <= 1'b0;
					sweep <= 1'b1;
					r <= '0;
					c <= '0;
				end
			end else if (sweep) begin
				if (c == last) begin
					c <= '0;
					r <= r + idx_t'(1);
					if (r == last) sweep <= 1'b0;
				end else begin
					c <= c + idx_t'(1);
				end
			end
		end
	end

	//////////////////////////////
	// buffers and the three stages
	always_ff @(posedge clk) begin
		if (i_go) pivot <= i_pivot;
		if (pre && pc != '0) begin
			row_buf[idx_t'(pc - idx_t'(1))] <= i_q_a; // data one behind address
			col_buf[idx_t'(pc - idx_t'(1))] <= i_q_b;
		end
		s1_last <= (r == last) && (c == last);
		s1_addr <= o_req_a.addr;
		s1_coef <= fix_t'(quot); // divide stage
		s1_top <= row_buf[c];
		s2_last <= s1_last;
		s2_addr <= s1_addr;
		s2_elem <= i_q_a;
		s2_prod <= fix_t'(prod >>> 16); // multiply stage
		s3_addr <= s2_addr;
		s3_data <= s2_elem - s2_prod; // subtract stage
	end

endmodule

// File: hw/row_pointer_table.sv
module row_pointer_table (
	input logic clk,
	input logic reset,
	input logic i_init,
	input logic i_rotate,
	input det_pkg::idx_t i_k,
	input det_pkg::size_t i_size,
	output det_pkg::row_base_t o_row_base,
	output logic o_neg
);
	import det_pkg::*;

	size_t span; // n-k rows in the active block

	assign span = i_size - size_t'(i_k);

	always_ff @(posedge clk) begin
		if (reset || i_init) begin
			for (int v = 0; v < MAX_N; v++) begin
				o_row_base[v] <= mx_addr_t'(v * MAX_N); // identity order
			end
			o_neg <= 1'b0;
		end else if (i_rotate) begin
			// last active row to the top, the rest slide down
			o_row_base[i_k] <= o_row_base[idx_t'(i_size - size_t'(1))];
			for (int v = 1; v < MAX_N; v++) begin
				if (v > int'(i_k) && v < int'(i_size)) begin
					o_row_base[v] <= o_row_base[v-1];
				end
			end
			if (!span[0]) o_neg <= ~o_neg; // even cycle length, odd permutation
		end
	end

endmodule

// File: hw/matrix_ram.sv
module matrix_ram #(
	parameter int MAX_N = det_pkg::MAX_N
) (
	input logic clk,
	input det_pkg::ram_req_t i_port_a,
	input det_pkg::ram_req_t i_port_b,
	output det_pkg::fix_t o_q_a,
	output det_pkg::fix_t o_q_b
);
	import det_pkg::*;

	fix_t mem [MAX_N*MAX_N]; // row major, row order via pointer table

	always_ff @(posedge clk) begin
		o_q_a <= mem[i_port_a.addr]; // read-first
		o_q_b <= mem[i_port_b.addr];
		if (i_port_a.we) mem[i_port_a.addr] <= i_port_a.wdata;
		if (i_port_b.we) mem[i_port_b.addr] <= i_port_b.wdata; // b wins a clash
	end

endmodule

// File: hw/det_pkg.sv
package det_pkg;

	parameter int MAX_N = 8; // largest matrix dimension, power of two
	localparam int IDX_W = $clog2(MAX_N);
	localparam int ADDR_W = 2 * IDX_W;

	typedef logic signed [31:0] fix_t; // q16.16 element
	typedef logic [ADDR_W-1:0] mx_addr_t; // row base + column
	typedef logic [IDX_W-1:0] idx_t;
	typedef logic [IDX_W:0] size_t; // 0..MAX_N
	typedef logic [6:0] wb_addr_t;
	typedef mx_addr_t [MAX_N-1:0] row_base_t; // one base per logical row

	localparam fix_t FIX_ONE = 32'sh0001_0000;

	// register map above the matrix words
	localparam wb_addr_t WB_CTRL = 7'd64;
	localparam wb_addr_t WB_STATUS = 7'd65;
	localparam wb_addr_t WB_RESULT = 7'd66;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SETUP,
		ST_PIVOT_READ,
		ST_PIVOT_CHECK,
		ST_ELIM,
		ST_NEXT_ITER,
		ST_DIAG,
		ST_FINISH
	} det_state_e;

	typedef struct packed {
		mx_addr_t addr;
		fix_t wdata;
		logic we;
	} ram_req_t;

endpackage
